//--- common/imuldiv_macros.svh
// width and iteration constants shared by the mul/div unit
// STEPS must fit in a CNT_W-bit counter and RLEN is twice XLEN

`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

// --------------------
// datapath widths
// --------------------

// operand width
`define IMULDIV_XLEN 32

// full result width, product or {remainder, quotient}
`define IMULDIV_RLEN 64

// --------------------
// iteration control
// --------------------

// one shift step per operand bit
`define IMULDIV_STEPS 32

// step counter width, one bit of headroom over STEPS-1
`define IMULDIV_CNT_W 6

`endif

//--- common/imuldiv_pkg.sv
// types shared by the iterative mul/div unit
// code 2'd3 is left unused and is handled as FN_MUL by the front end

`default_nettype none

package imuldiv_pkg;

`include "imuldiv_macros.svh"

  // --------------------
  // request function code
  // --------------------

  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } muldiv_fn_t;

  // --------------------
  // block FSM states
  // --------------------

  // same three-state shape in both control FSMs
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } iter_state_t;

  // divide response, remainder packed above quotient
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quot;
  } div_result_t;

endpackage

`default_nettype wire

//--- common/muldiv_req_if.sv
// request bundle from the front end to one mul or div block
// fn, a and b are only meaningful while val is high

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

interface muldiv_req_if
  import imuldiv_pkg::*;
();

  // handshake
  logic                     val;
  logic                     rdy;

  // payload
  muldiv_fn_t               fn;
  logic [`IMULDIV_XLEN-1:0] a;
  logic [`IMULDIV_XLEN-1:0] b;

  // front end drives val and payload
  modport src (output val, output fn, output a, output b, input rdy);

  // control FSM sees only the handshake
  modport ctrl (input val, output rdy);

  // datapath reads the payload
  modport dpath (input fn, input a, input b);

endinterface

`default_nettype wire

//--- dv/imuldiv_props.sv
// handshake rules checked on the top-level ports of the mul/div unit
// bound into every imuldiv_iterative instance

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_props (
  input wire logic                     clk,
  input wire logic                     reset,
  input wire logic                     req_rdy,
  input wire logic                     resp_val,
  input wire logic                     resp_rdy,
  input wire logic [`IMULDIV_RLEN-1:0] resp_result
);

  // --------------------
  // response port
  // --------------------

  // a stalled response keeps both val and data
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else $error("response changed while stalled");

  // only one operation in flight
  no_req_during_resp: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else $error("request ready while a response is pending");

  // reset clears any pending response
  reset_quiet: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("response valid after a reset edge");

endmodule

bind imuldiv_iterative imuldiv_props u_props (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

`default_nettype wire

//--- dv/imuldiv_tb.sv
// testbench for the iterative mul/div unit, one operation in flight at a time
// random operands and resp_rdy stalls from a fixed seed, checked against a local model

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int LATENCY       = `IMULDIV_STEPS + 1;
  localparam int REQ_TIMEOUT   = 400;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int NUM_RANDOM    = 300;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  muldiv_fn_t               req_fn;
  logic [`IMULDIV_XLEN-1:0] req_a;
  logic [`IMULDIV_XLEN-1:0] req_b;
  logic                     resp_val;
  logic                     resp_rdy;
  logic [`IMULDIV_RLEN-1:0] resp_result;

  // monitor state
  logic [`IMULDIV_RLEN-1:0] exp_q [$];
  bit                       pending;
  bit                       stall_en;
  int                       cycle;
  int                       acc_edge;

  imuldiv_iterative dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // edge counter, stable at the falling edge
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // consumer ready, randomly stalled once stalls are on
  always @(posedge clk) begin
    resp_rdy <= !stall_en || (($urandom % 4) != 0);
  end

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_result(input string name, input logic [`IMULDIV_RLEN-1:0] got,
                              input logic [`IMULDIV_RLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "result mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t %s got %b expected %b", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "wait timed out");
  endtask

  // --------------------
  // reference model
  // --------------------

  function automatic logic [`IMULDIV_RLEN-1:0] model_result(input muldiv_fn_t fn,
      input logic [`IMULDIV_XLEN-1:0] a, input logic [`IMULDIV_XLEN-1:0] b);
    logic signed [`IMULDIV_RLEN-1:0] sa;
    logic signed [`IMULDIV_RLEN-1:0] sb;
    logic signed [`IMULDIV_XLEN-1:0] sq;
    logic signed [`IMULDIV_XLEN-1:0] sr;
    sa = {{`IMULDIV_XLEN{a[`IMULDIV_XLEN-1]}}, a};
    sb = {{`IMULDIV_XLEN{b[`IMULDIV_XLEN-1]}}, b};
    if (fn == FN_DIV || fn == FN_DIVU) begin
      // zero divisor gives an all-ones quotient and the dividend as remainder
      if (b == '0) begin
        return {a, {`IMULDIV_XLEN{1'b1}}};
      end
      if (fn == FN_DIVU) begin
        return {a % b, a / b};
      end
      // most negative over minus one wraps back to itself
      if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        return {{`IMULDIV_XLEN{1'b0}}, a};
      end
      sq = $signed(a) / $signed(b);
      sr = $signed(a) % $signed(b);
      return {sr, sq};
    end
    return sa * sb;
  endfunction

  // extremes and zero show up often, the rest is uniform
  function automatic logic [`IMULDIV_XLEN-1:0] pick_operand();
    case ($urandom % 8)
      0: return 32'h0000_0000;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      3: return 32'h7fff_ffff;
      4: return 32'h0000_0001;
      5: return $urandom % 16;
      default: return $urandom;
    endcase
  endfunction

  // --------------------
  // monitor
  // --------------------

  // samples at the falling edge, each transfer lands on the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (pending) begin
        // no second request while one is outstanding
        check_flag("req_rdy", req_rdy, 1'b0);
        // resp_val rises in the 33rd cycle after the accept edge, then holds
        check_flag("resp_val", resp_val, (cycle - acc_edge) >= LATENCY);
        if (resp_val && resp_rdy) begin
          check_result("resp_result", resp_result, exp_q.pop_front());
          pending = 1'b0;
        end
      end else begin
        check_flag("resp_val", resp_val, 1'b0);
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(model_result(req_fn, req_a, req_b));
        pending  = 1'b1;
        // cycles after the accept edge are counted from here
        acc_edge = cycle;
      end
    end
  end

  // --------------------
  // driver
  // --------------------

  // called just after a rising edge, returns on the transfer edge
  task automatic drive_req(input muldiv_fn_t fn, input logic [`IMULDIV_XLEN-1:0] a,
                           input logic [`IMULDIV_XLEN-1:0] b);
    int waited;
    waited = 0;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(negedge clk);
    while (!req_rdy) begin
      waited++;
      if (waited > REQ_TIMEOUT) begin
        report_timeout("req_rdy to accept a request");
      end
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  initial begin
    int          waited;
    muldiv_fn_t  fn;
    void'($urandom(32'hddd1_0494));
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    stall_en = 1'b0;
    pending  = 1'b0;
    cycle    = 0;
    acc_edge = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
    @(posedge clk);

    // directed corners with resp_rdy held high
    drive_req(FN_MUL, 32'd7, -32'd3);
    drive_req(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    drive_req(FN_MUL, 32'h8000_0000, 32'hffff_ffff);
    drive_req(FN_MUL, 32'h0000_0000, 32'h1234_5678);
    drive_req(FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    drive_req(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    drive_req(FN_DIV, -32'd7, 32'd2);
    drive_req(FN_DIVU, 32'hffff_ffff, 32'd3);
    drive_req(FN_DIV, 32'd5, 32'd0);
    drive_req(FN_DIV, -32'd9, 32'd0);
    drive_req(FN_DIVU, 32'h8000_0000, 32'd0);

    // random traffic with consumer stalls and idle gaps
    stall_en <= 1'b1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      case ($urandom % 3)
        0: fn = FN_MUL;
        1: fn = FN_DIV;
        default: fn = FN_DIVU;
      endcase
      drive_req(fn, pick_operand(), pick_operand());
      repeat ($urandom % 3) @(posedge clk);
    end

    // drain the last response
    waited = 0;
    while (pending) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        report_timeout("the last response to drain");
      end
      @(posedge clk);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/imuldiv_front.sv
// front end of the mul/div unit, only one operation in flight
// the unused function code is sent to the multiplier

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_front
  import imuldiv_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reset,

  // top request port
  input  wire logic                      req_val,
  output logic                           req_rdy,
  input  wire muldiv_fn_t                req_fn,
  input  wire logic [`IMULDIV_XLEN-1:0]  req_a,
  input  wire logic [`IMULDIV_XLEN-1:0]  req_b,

  // requests to the two blocks
  muldiv_req_if.src                      mul_req,
  muldiv_req_if.src                      div_req,

  // responses from the two blocks
  input  wire logic                      mul_resp_val,
  input  wire logic                      div_resp_val,
  input  wire logic [`IMULDIV_RLEN-1:0]  mul_result,
  input  wire logic [`IMULDIV_RLEN-1:0]  div_result,
  output logic                           mul_resp_rdy,
  output logic                           div_resp_rdy,

  // top response port
  output logic                           resp_val,
  input  wire logic                      resp_rdy,
  output logic [`IMULDIV_RLEN-1:0]       resp_result
);

  logic busy_reg;
  logic unit_div_reg;
  logic sel_div;

  // --------------------
  // request steering
  // --------------------

  assign sel_div = (req_fn == FN_DIV) || (req_fn == FN_DIVU);

  assign mul_req.val = req_val && !busy_reg && !sel_div;
  assign div_req.val = req_val && !busy_reg && sel_div;

  // payload goes to both, only the chosen block sees val
  assign mul_req.fn = req_fn;
  assign mul_req.a  = req_a;
  assign mul_req.b  = req_b;
  assign div_req.fn = req_fn;
  assign div_req.a  = req_a;
  assign div_req.b  = req_b;

  assign req_rdy = !busy_reg && (sel_div ? div_req.rdy : mul_req.rdy);

  // busy from request transfer to response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_reg     <= 1'b0;
      unit_div_reg <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy_reg     <= 1'b1;
      unit_div_reg <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy_reg     <= 1'b0;
    end
  end

  // --------------------
  // response select
  // --------------------

  assign resp_val     = busy_reg && (unit_div_reg ? div_resp_val : mul_resp_val);
  assign resp_result  = unit_div_reg ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && busy_reg && !unit_div_reg;
  assign div_resp_rdy = resp_rdy && busy_reg && unit_div_reg;

endmodule

`default_nettype wire

//--- hdl/imuldiv_iterative.sv
// iterative multiply/divide unit, 33-cycle fixed latency per operation
// a new request is taken only after the previous response is consumed

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_iterative
  import imuldiv_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reset,

  input  wire logic                      req_val,
  output logic                           req_rdy,
  input  wire muldiv_fn_t                req_fn,
  input  wire logic [`IMULDIV_XLEN-1:0]  req_a,
  input  wire logic [`IMULDIV_XLEN-1:0]  req_b,

  output logic                           resp_val,
  input  wire logic                      resp_rdy,
  output logic [`IMULDIV_RLEN-1:0]       resp_result
);

  muldiv_req_if mul_req ();
  muldiv_req_if div_req ();

  logic                     mul_resp_val;
  logic                     mul_resp_rdy;
  logic [`IMULDIV_RLEN-1:0] mul_result;
  logic                     div_resp_val;
  logic                     div_resp_rdy;
  logic [`IMULDIV_RLEN-1:0] div_result;

  // multiplier strobes
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  // divider strobes
  logic ld_en;
  logic step_en;

  imuldiv_front u_front (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .mul_req      (mul_req.src),
    .div_req      (div_req.src),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_result  (resp_result)
  );

  // --------------------
  // multiplier
  // --------------------

  imul_ctrl u_imul_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req       (mul_req.ctrl),
    .resp_val  (mul_resp_val),
    .resp_rdy  (mul_resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

  imul_dpath u_imul_dpath (
    .clk       (clk),
    .reset     (reset),
    .req       (mul_req.dpath),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel),
    .result    (mul_result)
  );

  // --------------------
  // divider
  // --------------------

  idiv_ctrl u_idiv_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req      (div_req.ctrl),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .ld_en    (ld_en),
    .step_en  (step_en)
  );

  idiv_dpath u_idiv_dpath (
    .clk     (clk),
    .reset   (reset),
    .req     (div_req.dpath),
    .ld_en   (ld_en),
    .step_en (step_en),
    .result  (div_result)
  );

endmodule

`default_nettype wire

//--- idiv/idiv_ctrl.sv
// divider control FSM, one request at a time with fixed latency
// operands load on the accept edge and then 32 restoring steps follow

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module idiv_ctrl
  import imuldiv_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,

  muldiv_req_if.ctrl  req,

  output logic        resp_val,
  input  wire logic   resp_rdy,

  // load operands, run one shift/subtract step
  output logic        ld_en,
  output logic        step_en
);

  localparam int unsigned LAST_STEP = `IMULDIV_STEPS - 1;
  localparam logic [`IMULDIV_CNT_W-1:0] CNT_ONE = 'd1;

  iter_state_t               state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                      req_go;
  logic                      resp_go;

  assign req_go  = req.val && req.rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------
  // state and step count
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          if (count == LAST_STEP[`IMULDIV_CNT_W-1:0]) begin
            state <= ST_DONE;
          end else begin
            count <= count + CNT_ONE;
          end
        end
        ST_DONE: begin
          // result holds until the consumer takes it
          if (resp_go) begin
            state <= ST_IDLE;
            count <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // outputs from state
  // --------------------

  assign req.rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);
  assign ld_en    = req_go;
  assign step_en  = (state == ST_CALC);

endmodule

`default_nettype wire

//--- idiv/idiv_dpath.sv
// divider datapath, restoring division on operand magnitudes
// FN_DIV is signed and FN_DIVU unsigned, result is {remainder, quotient}
// a zero divisor gives an all-ones quotient and the dividend as remainder

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module idiv_dpath
  import imuldiv_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reset,

  muldiv_req_if.dpath                    req,

  input  wire logic                      ld_en,
  input  wire logic                      step_en,

  output logic [`IMULDIV_RLEN-1:0]       result
);

  // flags latched at load, cleared by reset
  muldiv_fn_t                fn_reg;
  logic                      quot_neg_reg;
  logic                      rem_neg_reg;
  logic                      zero_reg;

  // divisor magnitude and the remainder/quotient pair
  logic [`IMULDIV_XLEN-1:0]  div_reg;
  logic [`IMULDIV_XLEN-1:0]  rem_reg;
  logic [`IMULDIV_XLEN-1:0]  quot_reg;

  logic                      is_signed;
  logic [`IMULDIV_XLEN-1:0]  a_in;
  logic [`IMULDIV_XLEN-1:0]  b_in;
  logic [`IMULDIV_XLEN:0]    rem_shift;
  logic [`IMULDIV_XLEN:0]    rem_diff;
  logic                      fits;
  logic                      signed_out;
  div_result_t               res;

  // --------------------
  // operand capture
  // --------------------

  assign is_signed = (req.fn == FN_DIV);

  // signed requests divide magnitudes, unsigned take raw bits
  assign a_in = (is_signed && req.a[`IMULDIV_XLEN-1]) ? -req.a : req.a;
  assign b_in = (is_signed && req.b[`IMULDIV_XLEN-1]) ? -req.b : req.b;

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg       <= FN_DIVU;
      quot_neg_reg <= 1'b0;
      rem_neg_reg  <= 1'b0;
      zero_reg     <= 1'b0;
    end else if (ld_en) begin
      fn_reg       <= req.fn;
      // quotient sign from both operands, remainder follows the dividend
      quot_neg_reg <= req.a[`IMULDIV_XLEN-1] ^ req.b[`IMULDIV_XLEN-1];
      rem_neg_reg  <= req.a[`IMULDIV_XLEN-1];
      zero_reg     <= (req.b == '0);
    end
  end

  // --------------------
  // restoring step
  // --------------------

  // shifted remainder can exceed 32 bits, so compare at 33
  assign rem_shift = {rem_reg, quot_reg[`IMULDIV_XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, div_reg};
  assign fits      = (rem_shift >= {1'b0, div_reg});

  always_ff @(posedge clk) begin
    if (ld_en) begin
      div_reg  <= b_in;
      rem_reg  <= '0;
      quot_reg <= a_in;
    end else if (step_en) begin
      // dividend bits leave the top of quot as quotient bits enter the bottom
      rem_reg  <= fits ? rem_diff[`IMULDIV_XLEN-1:0] : rem_shift[`IMULDIV_XLEN-1:0];
      quot_reg <= {quot_reg[`IMULDIV_XLEN-2:0], fits};
    end
  end

  // --------------------
  // sign fix and packing
  // --------------------

  assign signed_out = (fn_reg == FN_DIV);

  always_comb begin
    res.rem  = (signed_out && rem_neg_reg) ? -rem_reg : rem_reg;
    res.quot = (signed_out && quot_neg_reg) ? -quot_reg : quot_reg;
    // zero divisor: every step fits, so rem already holds the dividend
    if (zero_reg) begin
      res.quot = '1;
    end
  end

  assign result = res;

endmodule

`default_nettype wire

//--- imul/imul_ctrl.sv
// multiplier control FSM, one request at a time with fixed latency
// operands load on the accept edge and then 32 shift steps follow

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imul_ctrl
  import imuldiv_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,

  muldiv_req_if.ctrl  req,

  output logic        resp_val,
  input  wire logic   resp_rdy,

  // a_en/b_en update the operand registers this cycle
  // mux_sel low takes fresh operands, high takes the shifted value
  output logic        a_en,
  output logic        a_mux_sel,
  output logic        b_en,
  output logic        b_mux_sel
);

  localparam int unsigned LAST_STEP = `IMULDIV_STEPS - 1;
  localparam logic [`IMULDIV_CNT_W-1:0] CNT_ONE = 'd1;

  iter_state_t               state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                      req_go;
  logic                      resp_go;

  assign req_go  = req.val && req.rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------
  // state and step count
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state <= ST_CALC;
            count <= '0;
          end
        end
        ST_CALC: begin
          // last shift step moves straight to the response
          if (count == LAST_STEP[`IMULDIV_CNT_W-1:0]) begin
            state <= ST_DONE;
          end else begin
            count <= count + CNT_ONE;
          end
        end
        ST_DONE: begin
          if (resp_go) begin
            state <= ST_IDLE;
            count <= '0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // outputs from state
  // --------------------

  assign req.rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // load strobes only on the accept edge, shift strobes through CALC
  assign a_en      = req_go || (state == ST_CALC);
  assign b_en      = req_go || (state == ST_CALC);
  assign a_mux_sel = (state == ST_CALC);
  assign b_mux_sel = (state == ST_CALC);

endmodule

`default_nettype wire

//--- imul/imul_dpath.sv
// multiplier datapath, signed operands with the full-width product
// magnitudes are multiplied and the sign is applied at the output

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imul_dpath (
  input  wire logic                      clk,
  input  wire logic                      reset,

  muldiv_req_if.dpath                    req,

  input  wire logic                      a_en,
  input  wire logic                      a_mux_sel,
  input  wire logic                      b_en,
  input  wire logic                      b_mux_sel,

  output logic [`IMULDIV_RLEN-1:0]       result
);

  // operand sign flags, captured at load
  logic                      sign_a_reg;
  logic                      sign_b_reg;

  // multiplicand widened so it can shift left for 32 steps
  logic [`IMULDIV_RLEN-1:0]  a_reg;
  logic [`IMULDIV_XLEN-1:0]  b_reg;
  logic [`IMULDIV_RLEN-1:0]  acc_reg;

  logic [`IMULDIV_XLEN-1:0]  a_mag;
  logic [`IMULDIV_XLEN-1:0]  b_mag;
  logic [`IMULDIV_RLEN-1:0]  a_mux_out;
  logic [`IMULDIV_XLEN-1:0]  b_mux_out;
  logic [`IMULDIV_RLEN-1:0]  acc_next;
  logic                      load;

  // --------------------
  // operand muxes
  // --------------------

  // most negative value maps to 2**31, still right as unsigned
  assign a_mag = req.a[`IMULDIV_XLEN-1] ? -req.a : req.a;
  assign b_mag = req.b[`IMULDIV_XLEN-1] ? -req.b : req.b;

  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{`IMULDIV_XLEN{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  // add the shifted multiplicand when this multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  assign load = a_en && !a_mux_sel;

  // sign flags are the only state here that reset clears
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      sign_a_reg <= req.a[`IMULDIV_XLEN-1];
      sign_b_reg <= req.b[`IMULDIV_XLEN-1];
    end
  end

  // --------------------
  // shift/add registers
  // --------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
    if (load) begin
      acc_reg <= '0;
    end else if (a_en) begin
      acc_reg <= acc_next;
    end
  end

  // negate when exactly one operand was negative
  assign result = (sign_a_reg ^ sign_b_reg) ? -acc_reg : acc_reg;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the mul/div testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module imuldiv_tb -o imuldiv_sim \
  && ./obj_dir/imuldiv_sim 2>&1 | tee sim.log \
  || { echo "simulation build or run returned an error"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- sources.f
+incdir+common
common/imuldiv_pkg.sv
common/muldiv_req_if.sv
imul/imul_ctrl.sv
imul/imul_dpath.sv
idiv/idiv_ctrl.sv
idiv/idiv_dpath.sv
hdl/imuldiv_front.sv
hdl/imuldiv_iterative.sv
dv/imuldiv_props.sv
dv/imuldiv_tb.sv
